//--- verilog/det_params_pkg.sv
`default_nettype none

package det_params_pkg;

    // Signed width of one I or Q component.
    localparam int SAMPLE_W = 16;

    // Instantaneous power is unsigned and holds the sum of two squares.
    localparam int POWER_W = 32;

    localparam int INDEX_W = 16; // Sample index in events, wraps around.

    // Detection shift field of the configuration.
    localparam int SHIFT_W = 4;

    localparam int HOLD_W = 8; // Hold interval of the peak picker.

    // Window length of the moving average unless the top level overrides it.
    localparam int DEFAULT_WINDOW_LEN = 8;

endpackage

`default_nettype wire

//--- verilog/det_types_pkg.sv
`default_nettype none

package det_types_pkg;

    // One complex baseband sample.
    typedef struct packed {
        logic signed [det_params_pkg::SAMPLE_W-1:0] i;
        logic signed [det_params_pkg::SAMPLE_W-1:0] q;
    } iq_sample_t;

    typedef struct packed {
        logic                             valid;
        logic [det_params_pkg::POWER_W-1:0] power;
    } power_t;

    // Static detector configuration.
    typedef struct packed {
        logic                               enable;
        logic [det_params_pkg::SHIFT_W-1:0] detection_shift;
        logic [det_params_pkg::POWER_W-1:0] noise_limit;
        logic [det_params_pkg::HOLD_W-1:0]  hold_len; // Zero acts as one.
    } det_cfg_t;

    typedef struct packed {
        logic                               valid;
        logic                               hit;
        logic [det_params_pkg::POWER_W-1:0] score; // Power above threshold.
    } hit_t;

    // Strongest hit of one burst.
    typedef struct packed {
        logic [det_params_pkg::INDEX_W-1:0] index;
        logic [det_params_pkg::POWER_W-1:0] score;
    } peak_event_t;

endpackage

`default_nettype wire

//--- verilog/power_calc.sv
`default_nettype none

module power_calc (
    input  wire logic                    clk_i,
    input  wire logic                    reset_ni,
    input  wire logic                    valid_i,
    input  wire det_types_pkg::iq_sample_t sample_i,
    output det_types_pkg::power_t        power_o
);

    localparam int PROD_W = 2 * det_params_pkg::SAMPLE_W;

    logic signed [PROD_W-1:0] i_sq;
    logic signed [PROD_W-1:0] q_sq;
    logic [det_params_pkg::POWER_W-1:0] power_sum;

    // Squares are never negative, so the sum fits the unsigned power width.
    always_comb begin
        i_sq = sample_i.i * sample_i.i;
        q_sq = sample_i.q * sample_i.q;
        power_sum = det_params_pkg::POWER_W'(unsigned'(i_sq))
                  + det_params_pkg::POWER_W'(unsigned'(q_sq));
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            power_o.valid <= 1'b0;
        end else begin
            power_o.valid <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            power_o.power <= power_sum; // Held between strobes.
        end
    end

    // The detector downstream counts strobes, so an unknown one would corrupt warm-up.
    a_valid_known : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        !$isunknown(power_o.valid)
    );

endmodule

`default_nettype wire

//--- verilog/peak_detector.sv
`default_nettype none

module peak_detector #(
    parameter int WINDOW_LEN = det_params_pkg::DEFAULT_WINDOW_LEN
) (
    input  wire logic                  clk_i,
    input  wire logic                  reset_ni,
    input  wire det_types_pkg::power_t power_i,
    input  wire det_types_pkg::det_cfg_t cfg_i,
    output det_types_pkg::hit_t        hit_o
);

    localparam int L = $clog2(WINDOW_LEN);
    localparam int POWER_W = det_params_pkg::POWER_W;
    localparam int SHIFT_W = det_params_pkg::SHIFT_W;
    localparam int SUM_W = POWER_W + L;
    // Room for the largest left shift of the sum, so no bit is lost.
    localparam int THR_W = SUM_W + (1 << SHIFT_W) - 1;
    localparam int WARM_W = L + 1;

    if (WINDOW_LEN < 2 || WINDOW_LEN > 64 || WINDOW_LEN != (1 << L)) begin : g_len_check
        $error("WINDOW_LEN must be a power of two from 2 to 64.");
    end

    logic [POWER_W-1:0] delay_q [WINDOW_LEN]; // Entry 0 is the newest power.
    logic [SUM_W-1:0]   sum_q;
    logic [WARM_W-1:0]  warm_cnt_q;

    logic               warm_done;
    logic [THR_W-1:0]   sum_ext;
    logic [THR_W-1:0]   power_ext;
    logic [THR_W-1:0]   threshold;
    logic [THR_W-1:0]   margin;
    logic               is_hit;

    assign warm_done = (warm_cnt_q == WARM_W'(WINDOW_LEN));

    // The sum covers the previous WINDOW_LEN powers, scaled by 2^(shift - L).
    always_comb begin
        sum_ext = THR_W'(sum_q);
        power_ext = THR_W'(power_i.power);
        if (cfg_i.detection_shift < SHIFT_W'(L)) begin
            threshold = sum_ext >> (SHIFT_W'(L) - cfg_i.detection_shift);
        end else begin
            threshold = sum_ext << (cfg_i.detection_shift - SHIFT_W'(L));
        end
        margin = power_ext - threshold;
        is_hit = power_i.valid && warm_done && cfg_i.enable
              && (power_ext > threshold)
              && (power_i.power > cfg_i.noise_limit);
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int n = 0; n < WINDOW_LEN; n++) begin
                delay_q[n] <= '0;
            end
            sum_q <= '0;
            warm_cnt_q <= '0;
        end else if (power_i.valid) begin
            delay_q[0] <= power_i.power;
            for (int n = 1; n < WINDOW_LEN; n++) begin
                delay_q[n] <= delay_q[n-1];
            end
            // The oldest entry leaves the window as the newest enters.
            sum_q <= sum_q + SUM_W'(power_i.power) - SUM_W'(delay_q[WINDOW_LEN-1]);
            if (!warm_done) begin
                warm_cnt_q <= warm_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            hit_o <= '0;
        end else begin
            hit_o.valid <= power_i.valid && warm_done;
            hit_o.hit <= is_hit;
            hit_o.score <= is_hit ? POWER_W'(margin) : '0; // Margin is below power on a hit.
        end
    end

    a_score_needs_hit : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        !hit_o.hit |-> (hit_o.score == '0)
    );

    // The picker counts its index on valid strobes only.
    a_hit_needs_valid : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        hit_o.hit |-> hit_o.valid
    );

endmodule

`default_nettype wire

//--- verilog/peak_picker.sv
`default_nettype none

module peak_picker (
    input  wire logic                               clk_i,
    input  wire logic                               reset_ni,
    input  wire det_types_pkg::hit_t                hit_i,
    input  wire logic [det_params_pkg::HOLD_W-1:0]  hold_len_i,
    output logic                                    event_valid_o,
    output det_types_pkg::peak_event_t              event_o
);

    localparam int HOLD_W = det_params_pkg::HOLD_W;

    logic [det_params_pkg::INDEX_W-1:0] index_q; // Index zero is the first output after warm-up.
    logic                               open_q;
    logic [HOLD_W-1:0]                  hold_cnt_q;
    det_types_pkg::peak_event_t         best_q;

    logic [HOLD_W-1:0] hold_load;
    logic              better;

    always_comb begin
        hold_load = (hold_len_i == '0) ? HOLD_W'(1) : hold_len_i;
        better = hit_i.hit && (hit_i.score > best_q.score); // Ties keep the earlier hit.
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            index_q <= '0;
            open_q <= 1'b0;
            hold_cnt_q <= '0;
            event_valid_o <= 1'b0;
        end else begin
            event_valid_o <= 1'b0;
            if (hit_i.valid) begin
                index_q <= index_q + 1'b1;
                if (!open_q) begin
                    if (hit_i.hit) begin
                        open_q <= 1'b1;
                        hold_cnt_q <= hold_load;
                    end
                end else if (better) begin
                    hold_cnt_q <= hold_load;
                end else if (hold_cnt_q == HOLD_W'(1)) begin
                    // This value runs the counter out, so the group closes here.
                    open_q <= 1'b0;
                    hold_cnt_q <= '0;
                    event_valid_o <= 1'b1;
                end else begin
                    hold_cnt_q <= hold_cnt_q - 1'b1;
                end
            end
        end
    end

    // The best hit of a group, opened or replaced.
    always_ff @(posedge clk_i) begin
        if (hit_i.valid && hit_i.hit && (!open_q || better)) begin
            best_q.index <= index_q;
            best_q.score <= hit_i.score;
        end
    end

    assign event_o = best_q;

    // A new group needs a hit after the close, so events are at least two cycles apart.
    a_event_single : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        event_valid_o |=> !event_valid_o
    );

endmodule

`default_nettype wire

//--- verilog/sync_detector.sv
`default_nettype none

module sync_detector #(
    parameter int WINDOW_LEN = det_params_pkg::DEFAULT_WINDOW_LEN
) (
    input  wire logic                      clk_i,
    input  wire logic                      reset_ni,
    input  wire logic                      sample_valid_i,
    input  wire det_types_pkg::iq_sample_t sample_i,
    input  wire det_types_pkg::det_cfg_t   cfg_i,
    output det_types_pkg::hit_t            hit_o,
    output logic                           event_valid_o,
    output det_types_pkg::peak_event_t     event_o
);

    det_types_pkg::power_t power;

    // Sample to power, one cycle.
    power_calc power_calc_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .valid_i  (sample_valid_i),
        .sample_i (sample_i),
        .power_o  (power)
    );

    // Power to hit, one cycle, so hit_o follows the sample by two edges.
    peak_detector #(
        .WINDOW_LEN (WINDOW_LEN)
    ) peak_detector_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .power_i  (power),
        .cfg_i    (cfg_i),
        .hit_o    (hit_o)
    );

    peak_picker peak_picker_i (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .hit_i         (hit_o),
        .hold_len_i    (cfg_i.hold_len),
        .event_valid_o (event_valid_o),
        .event_o       (event_o)
    );

endmodule

`default_nettype wire

//--- verif/sync_detector_model.svh
`ifndef SYNC_DETECTOR_MODEL_SVH
`define SYNC_DETECTOR_MODEL_SVH

// Detector state of the model.
logic [POWER_W-1:0] model_history [$]; // Front is the oldest power in the window.
logic [63:0]        model_sum;

// Picker state of the model.
logic [INDEX_W-1:0]          model_index;
logic                        model_open;
int                          model_hold;
det_types_pkg::peak_event_t  model_best;
det_types_pkg::peak_event_t  expected_events [$];

function automatic logic [POWER_W-1:0] sample_power(input det_types_pkg::iq_sample_t s);
    longint i_part;
    longint q_part;
    i_part = longint'($signed(s.i));
    q_part = longint'($signed(s.q));
    return POWER_W'(i_part * i_part + q_part * q_part);
endfunction

task automatic clear_model();
    model_history.delete();
    model_sum = '0;
    model_index = '0;
    model_open = 1'b0;
    model_hold = 0;
    model_best = '0;
    expected_events.delete();
endtask

// Threshold is the window sum scaled by 2^(shift - L), kept at full precision.
task automatic predict_hit(input det_types_pkg::iq_sample_t s,
                           input det_types_pkg::det_cfg_t c,
                           output det_types_pkg::hit_t h);
    logic [63:0] power;
    logic [63:0] threshold;
    int          shift;
    power = 64'(sample_power(s));
    shift = int'(c.detection_shift);
    h = '0;
    if (model_history.size() == WINDOW_LEN) begin
        if (shift < L) begin
            threshold = model_sum >> (L - shift);
        end else begin
            threshold = model_sum << (shift - L);
        end
        h.valid = 1'b1;
        if (c.enable && (power > threshold) && (power > 64'(c.noise_limit))) begin
            h.hit = 1'b1;
            h.score = POWER_W'(power - threshold);
        end
        model_sum = model_sum - 64'(model_history.pop_front());
    end
    model_history.push_back(POWER_W'(power));
    model_sum = model_sum + power;
endtask

task automatic pick_peak(input det_types_pkg::hit_t h, input logic [HOLD_W-1:0] hold_len);
    int load;
    load = (hold_len == '0) ? 1 : int'(hold_len);
    if (h.valid) begin
        if (!model_open) begin
            if (h.hit) begin
                model_open = 1'b1;
                model_best.index = model_index;
                model_best.score = h.score;
                model_hold = load;
            end
        end else if (h.hit && (h.score > model_best.score)) begin
            model_best.index = model_index; // A tie keeps the earlier hit.
            model_best.score = h.score;
            model_hold = load;
        end else begin
            model_hold = model_hold - 1;
            if (model_hold == 0) begin
                expected_events.push_back(model_best);
                model_open = 1'b0;
            end
        end
        model_index = model_index + 1'b1;
    end
endtask

`endif

//--- verif/sync_detector_tb.sv
`default_nettype none

module sync_detector_tb;

    localparam int WINDOW_LEN = det_params_pkg::DEFAULT_WINDOW_LEN;
    localparam int L = $clog2(WINDOW_LEN);
    localparam int SAMPLE_W = det_params_pkg::SAMPLE_W;
    localparam int POWER_W = det_params_pkg::POWER_W;
    localparam int INDEX_W = det_params_pkg::INDEX_W;
    localparam int SHIFT_W = det_params_pkg::SHIFT_W;
    localparam int HOLD_W = det_params_pkg::HOLD_W;
    localparam int DRAIN_TIMEOUT = 200;

    logic                        clk_i = 1'b0;
    logic                        reset_ni;
    logic                        sample_valid_i;
    det_types_pkg::iq_sample_t   sample_i;
    det_types_pkg::det_cfg_t     cfg_i;
    det_types_pkg::hit_t         hit_o;
    logic                        event_valid_o;
    det_types_pkg::peak_event_t  event_o;

    det_types_pkg::det_cfg_t cfg; // Configuration that the next cycle drives.
    det_types_pkg::hit_t     hit_pipe [3]; // Entry 2 is due on hit_o this cycle.
    integer                  seed;
    int                      burst_left;

    `include "sync_detector_model.svh"

    sync_detector sync_detector_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .cfg_i          (cfg_i),
        .hit_o          (hit_o),
        .event_valid_o  (event_valid_o),
        .event_o        (event_o)
    );

    always #5 clk_i = ~clk_i;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_hit(input det_types_pkg::hit_t actual,
                             input det_types_pkg::hit_t expected);
        if (actual !== expected) begin
            report_failure($sformatf(
                "mismatch at %0t: hit_o (valid hit score) is %b %b %0d, expected %b %b %0d",
                $time, actual.valid, actual.hit, actual.score,
                expected.valid, expected.hit, expected.score));
        end
    endtask

    task automatic check_event(input det_types_pkg::peak_event_t actual,
                               input det_types_pkg::peak_event_t expected);
        if (actual !== expected) begin
            report_failure($sformatf(
                "mismatch at %0t: event_o is index=%0d score=%0d, expected index=%0d score=%0d",
                $time, actual.index, actual.score, expected.index, expected.score));
        end
    endtask

    // One clock cycle. Inputs change on the rising edge and outputs are checked on the falling one.
    task automatic step_cycle(input logic valid, input det_types_pkg::iq_sample_t sample,
                              input logic rst_n);
        det_types_pkg::hit_t predicted;
        predicted = '0;
        @(posedge clk_i);
        reset_ni <= rst_n;
        sample_valid_i <= valid && rst_n;
        sample_i <= sample;
        cfg_i <= cfg;
        if (valid && rst_n) begin
            predict_hit(sample, cfg, predicted);
        end
        hit_pipe[2] = hit_pipe[1];
        hit_pipe[1] = hit_pipe[0];
        hit_pipe[0] = predicted;
        @(negedge clk_i);
        check_hit(hit_o, hit_pipe[2]);
        if ($isunknown(event_valid_o)) begin
            report_failure("event_valid_o is unknown after reset");
        end else if (event_valid_o) begin
            if (expected_events.size() == 0) begin
                report_failure("a peak event appeared that the model does not expect");
            end else begin
                check_event(event_o, expected_events.pop_front());
            end
        end
        pick_peak(hit_pipe[2], cfg.hold_len);
        // The DUT takes this reset on the next edge, so samples still in flight are lost.
        if (!rst_n) begin
            clear_model();
            hit_pipe[1] = '0;
            hit_pipe[0] = '0;
        end
    endtask

    // Mostly quiet noise with occasional bursts of large samples.
    task automatic make_sample(output logic valid, output det_types_pkg::iq_sample_t s);
        valid = (($unsigned($random(seed)) % 10) < 7);
        if (burst_left == 0 && ($unsigned($random(seed)) % 40) == 0) begin
            burst_left = 4 + int'($unsigned($random(seed)) % 12);
        end
        if (burst_left > 0) begin
            s.i = SAMPLE_W'($random(seed) % 16000);
            s.q = SAMPLE_W'($random(seed) % 16000);
            if (valid) begin
                burst_left = burst_left - 1;
            end
        end else begin
            s.i = SAMPLE_W'($random(seed) % 40);
            s.q = SAMPLE_W'($random(seed) % 40);
        end
    endtask

    task automatic run_random(input int cycles);
        logic                      valid;
        det_types_pkg::iq_sample_t s;
        for (int n = 0; n < cycles; n++) begin
            make_sample(valid, s);
            step_cycle(valid, s, 1'b1);
        end
    endtask

    // Idle cycles run first, so no valid sample in flight sees the change.
    task automatic set_config(input logic enable, input int shift,
                              input logic [POWER_W-1:0] noise_limit);
        det_types_pkg::iq_sample_t idle;
        idle = '0;
        for (int n = 0; n < 3; n++) begin
            step_cycle(1'b0, idle, 1'b1);
        end
        cfg.enable = enable;
        cfg.detection_shift = SHIFT_W'(shift);
        cfg.noise_limit = noise_limit;
        cfg.hold_len = HOLD_W'($unsigned($random(seed)) % 6);
    endtask

    // With shift zero the second threshold is an eighth of 64, so both scores are 64.
    task automatic run_tie_case();
        det_types_pkg::iq_sample_t s;
        s = '0;
        for (int n = 0; n < 2 * WINDOW_LEN + 8; n++) begin
            step_cycle(1'b1, s, 1'b1);
        end
        s.i = SAMPLE_W'(8);
        step_cycle(1'b1, s, 1'b1);
        s.i = SAMPLE_W'(6);
        s.q = SAMPLE_W'(6);
        step_cycle(1'b1, s, 1'b1);
        s = '0;
        for (int n = 0; n < 12; n++) begin
            step_cycle(1'b1, s, 1'b1);
        end
    endtask

    // Quiet valid samples run the hold counter out, so open groups close.
    task automatic drain_events();
        det_types_pkg::iq_sample_t quiet;
        int                        waited;
        quiet = '0;
        waited = 0;
        while (expected_events.size() != 0 || model_open) begin
            if (waited >= DRAIN_TIMEOUT) begin
                report_failure("an expected peak event never arrived before the timeout");
            end else begin
                step_cycle(1'b1, quiet, 1'b1);
                waited++;
            end
        end
        for (int n = 0; n < 8; n++) begin
            step_cycle(1'b1, quiet, 1'b1);
        end
    endtask

    initial begin
        det_types_pkg::iq_sample_t quiet;
        quiet = '0;
        seed = 85576;
        burst_left = 0;
        reset_ni = 1'b0;
        sample_valid_i = 1'b0;
        sample_i = '0;
        cfg = '0;
        cfg_i = '0;
        for (int n = 0; n < 3; n++) begin
            hit_pipe[n] = '0;
        end
        clear_model();
        for (int n = 0; n < 3; n++) begin
            step_cycle(1'b0, quiet, 1'b0);
        end

        set_config(1'b1, L - 2, POWER_W'(5000));
        cfg.hold_len = '0; // A zero hold acts as one.
        run_random(400);
        set_config(1'b1, L, '0);
        run_random(400);
        set_config(1'b1, L + 2, POWER_W'(2000));
        run_random(400);
        set_config(1'b0, L, '0);
        run_random(300);
        set_config(1'b1, L, '1); // Above the largest possible power.
        run_random(300);

        set_config(1'b1, 0, '0);
        cfg.hold_len = HOLD_W'(4);
        run_tie_case();

        set_config(1'b1, L - 1, POWER_W'(1000));
        run_random(200);
        burst_left = 20;
        run_random(8);
        for (int n = 0; n < 4; n++) begin
            step_cycle(1'b0, quiet, 1'b0);
        end
        run_random(400);

        drain_events();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verif
verilog/det_params_pkg.sv
verilog/det_types_pkg.sv
verilog/power_calc.sv
verilog/peak_detector.sv
verilog/peak_picker.sv
verilog/sync_detector.sv
verif/sync_detector_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status is the verdict.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module sync_detector_tb \
    -f flist.f \
    -o sync_detector_sim

./obj_dir/sync_detector_sim
